// ==== tb.f ====
+incdir+.
dsp_pkg.sv
dsp_multiplier.sv
dsp_accumulator.sv
dsp_output_stage.sv
dsp_mac_top.sv
tb_dsp_mac.sv

// ==== tb_dsp_model.svh ====
// DSP MAC reference model
`ifndef TB_DSP_MODEL_SVH
`define TB_DSP_MODEL_SVH

    // Result limits at full 64-bit precision
    localparam longint Z_UMAX = (longint'(1) <<< ZW) - 1;
    localparam longint Z_SMAX = (longint'(1) <<< (ZW - 1)) - 1;
    localparam longint Z_SMIN = -(longint'(1) <<< (ZW - 1));

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // True product, each operand taken as flagged
    function automatic logic [63:0] product_of(input logic [AW-1:0] a_v,
                                               input logic [BW-1:0] b_v,
                                               input logic ua, input logic ub);
        longint sa;
        longint sb;
        sa = ua ? longint'(a_v) : longint'($signed(a_v));
        sb = ub ? longint'(b_v) : longint'($signed(b_v));
        return sa * sb;
    endfunction

    // Shift, round half up, then clamp or wrap to ZW bits
    function automatic logic [ZW-1:0] post_process(input logic [63:0] acc,
                                                   input dsp_pkg::shift_t sh,
                                                   input logic rnd, input logic sat,
                                                   input logic uns);
        longint v;
        v = $signed(acc) >>> sh;
        if (rnd && sh != 0) begin
            // Last bit shifted out
            v = v + acc[sh - 1];
        end
        if (sat && uns) begin
            if (v < 0) begin
                v = 0;
            end else if (v > Z_UMAX) begin
                v = Z_UMAX;
            end
        end else if (sat) begin
            if (v > Z_SMAX) begin
                v = Z_SMAX;
            end else if (v < Z_SMIN) begin
                v = Z_SMIN;
            end
        end
        return v[ZW-1:0];
    endfunction

`endif

// ==== tb_dsp_mac.sv ====
// DSP MAC testbench
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_mac;

    localparam int AW = dsp_pkg::DSP_A_WIDTH;
    localparam int BW = dsp_pkg::DSP_B_WIDTH;
    localparam int ZW = dsp_pkg::DSP_Z_WIDTH;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT = 200;

    `include "tb_dsp_model.svh"

    logic clock, s_reset, valid, unsigned_a, unsigned_b, subtract, round_en, saturate;
    logic [AW-1:0] a;
    logic [BW-1:0] b;
    dsp_pkg::feedback_t feedback;
    dsp_pkg::shift_t shift_right;
    logic [ZW-1:0] z;
    logic valid_out;

    // Model state and expected results in flight
    logic [63:0] model_acc;
    logic [ZW-1:0] exp_q[$];
    logic [ZW-1:0] exp_head;
    logic [31:0] rng;
    int value_errors, valid_errors, timeout_errors;

    dsp_mac_top dut_i (
        .clock_i       (clock),
        .s_reset       (s_reset),
        .valid_i       (valid),
        .a_i           (a),
        .b_i           (b),
        .unsigned_a_i  (unsigned_a),
        .unsigned_b_i  (unsigned_b),
        .feedback_i    (feedback),
        .subtract_i    (subtract),
        .shift_right_i (shift_right),
        .round_i       (round_en),
        .saturate_i    (saturate),
        .z_o           (z),
        .valid_o       (valid_out)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        s_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #2 s_reset = 1'b0;
    end

    // Outputs stay quiet while in reset, sampled mid-cycle
    a_reset_quiet: assert property (@(negedge clock) s_reset |-> (!valid_out && z == '0))
        else begin
            value_errors++;
            $display("[FAIL] valid_o/z_o in reset exp 0/0 got %h/%h",
                     $sampled(valid_out), $sampled(z));
        end
    // Exactly three cycles from sample to result
    a_valid_late: assert property (@(posedge clock) disable iff (s_reset) valid |-> ##3 valid_out)
        else begin
            valid_errors++;
            $display("[FAIL] valid_o exp 1 got %h", $sampled(valid_out));
        end
    a_valid_idle: assert property (@(posedge clock) disable iff (s_reset) !valid |-> ##3 !valid_out)
        else begin
            valid_errors++;
            $display("[FAIL] valid_o exp 0 got %h", $sampled(valid_out));
        end
    a_z_match: assert property (@(posedge clock) disable iff (s_reset) valid_out |-> z == exp_head)
        else begin
            value_errors++;
            $display("[FAIL] z_o exp %h got %h", $sampled(exp_head), $sampled(z));
        end

    // Retire the head once its result has been compared
    always @(posedge clock) begin
        if (!s_reset && valid_out) begin
            assert (exp_q.size() > 0) else begin
                valid_errors++;
                $display("Result appeared with no sample pending");
            end
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            refresh_head();
        end
    end

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic refresh_head();
        exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
    endtask

    // One sample, driven after the edge, model updated in step
    task automatic send(input logic [AW-1:0] a_v, input logic [BW-1:0] b_v,
                        input logic ua, input logic ub, input dsp_pkg::feedback_t fb,
                        input logic sub, input dsp_pkg::shift_t sh,
                        input logic rnd, input logic sat);
        logic [63:0] p;
        @(posedge clock);
        #2;
        valid = 1'b1;
        a = a_v;
        b = b_v;
        unsigned_a = ua;
        unsigned_b = ub;
        feedback = fb;
        subtract = sub;
        shift_right = sh;
        round_en = rnd;
        saturate = sat;
        p = product_of(a_v, b_v, ua, ub);
        if (sub) begin
            p = -p;
        end
        model_acc = (fb == dsp_pkg::FB_RESTART) ? p : model_acc + p;
        exp_q.push_back(post_process(model_acc, sh, rnd, sat, ua && ub));
        refresh_head();
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clock);
            #2 valid = 1'b0;
        end
    endtask

    task automatic finish_run();
        int total;
        total = value_errors + valid_errors + timeout_errors;
        $display("Errors: value %0d, valid %0d, timeout %0d",
                 value_errors, valid_errors, timeout_errors);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (s_reset !== 1'b0 && n < WAIT_LIMIT) begin
            @(posedge clock);
            n++;
        end
        if (s_reset !== 1'b0) begin
            timeout_errors++;
            $display("Timed out waiting for reset to be released");
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(posedge clock);
            n++;
        end
        if (exp_q.size() != 0) begin
            timeout_errors++;
            $display("Timed out with %0d results still in the pipeline", exp_q.size());
        end
    endtask

    initial begin
        logic [31:0] r1, r2, r3;
        {valid, unsigned_a, unsigned_b, subtract, round_en, saturate} = '0;
        a = '0;
        b = '0;
        feedback = dsp_pkg::FB_ACCUMULATE;
        shift_right = '0;
        model_acc = '0;
        exp_head = '0;
        rng = 32'h97bb_156f;
        value_errors = 0;
        valid_errors = 0;
        timeout_errors = 0;
        wait_reset_release();
        // Nothing comes out before the first sample
        repeat (4) begin
            @(posedge clock);
            #2;
            assert (z == '0 && valid_out == 1'b0) else begin
                value_errors++;
                $display("[FAIL] valid_o/z_o after reset exp 0/0 got %h/%h", valid_out, z);
            end
        end
        // Products in all four sign combinations, corner first
        for (int m = 0; m < 4; m++) begin
            send(20'h80000, 18'h20000, m[0], m[1], dsp_pkg::FB_RESTART, 0, 0, 0, 0);
            repeat (6) begin
                r1 = next_rand();
                r2 = next_rand();
                send(r1[AW-1:0], r2[BW-1:0], m[0], m[1], dsp_pkg::FB_RESTART, 0, 0, 0, 0);
            end
        end
        // Running sum with gaps, then a restart
        r1 = next_rand();
        send(r1[AW-1:0], r1[31:14], 0, 0, dsp_pkg::FB_RESTART, 0, 0, 0, 0);
        for (int i = 0; i < 12; i++) begin
            r1 = next_rand();
            r2 = next_rand();
            send(r1[AW-1:0], r2[BW-1:0], r1[31], r1[31], dsp_pkg::FB_ACCUMULATE,
                 r2[31], 0, 0, 0);
            if (i % 4 == 3) begin
                idle(3);
            end
        end
        send(20'h00123, 18'h00045, 0, 0, dsp_pkg::FB_RESTART, 0, 0, 0, 0);
        send(20'h00123, 18'h00045, 0, 0, dsp_pkg::FB_ACCUMULATE, 1, 0, 0, 0);
        // Shift and round over the whole range
        for (int i = 0; i < 24; i++) begin
            r1 = next_rand();
            r2 = next_rand();
            r3 = next_rand();
            send(r1[AW-1:0], r2[BW-1:0], 0, r3[8],
                 (i % 6 == 0) ? dsp_pkg::FB_RESTART : dsp_pkg::FB_ACCUMULATE,
                 r3[9], r3[5:0], r3[6], 0);
        end
        send(20'hfffff, 18'h3ffff, 0, 0, dsp_pkg::FB_RESTART, 0, 6'd63, 1, 0);
        send(20'h80000, 18'h00003, 0, 0, dsp_pkg::FB_RESTART, 0, 6'd1, 1, 0);
        // Signed clamp high, then low
        send(20'h80000, 18'h20000, 0, 0, dsp_pkg::FB_RESTART, 0, 0, 0, 1);
        repeat (2) send(20'h80000, 18'h20000, 0, 0, dsp_pkg::FB_ACCUMULATE, 0, 0, 0, 1);
        send(20'h7ffff, 18'h20000, 0, 0, dsp_pkg::FB_RESTART, 0, 0, 0, 1);
        repeat (2) send(20'h7ffff, 18'h20000, 0, 0, dsp_pkg::FB_ACCUMULATE, 0, 0, 0, 1);
        idle(2);
        // Unsigned overflow, underflow, then plain wrap
        send(20'hfffff, 18'h3ffff, 1, 1, dsp_pkg::FB_RESTART, 0, 0, 0, 1);
        send(20'hfffff, 18'h3ffff, 1, 1, dsp_pkg::FB_ACCUMULATE, 0, 0, 0, 1);
        send(20'hfffff, 18'h3ffff, 1, 1, dsp_pkg::FB_RESTART, 1, 0, 0, 1);
        send(20'hfffff, 18'h3ffff, 1, 1, dsp_pkg::FB_RESTART, 0, 0, 0, 0);
        send(20'hfffff, 18'h3ffff, 1, 1, dsp_pkg::FB_ACCUMULATE, 0, 0, 0, 0);
        send(20'h80000, 18'h20000, 0, 0, dsp_pkg::FB_ACCUMULATE, 0, 0, 0, 0);
        idle(4);
        wait_drain();
        repeat (4) @(posedge clock);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== dsp_mac_top.sv ====
// DSP multiply-accumulate top level
`timescale 1ns/1ps
`default_nettype none

module dsp_mac_top #(
    parameter int A_WIDTH = dsp_pkg::DSP_A_WIDTH,
    parameter int B_WIDTH = dsp_pkg::DSP_B_WIDTH,
    parameter int ACC_WIDTH = dsp_pkg::DSP_ACC_WIDTH,
    parameter int Z_WIDTH = dsp_pkg::DSP_Z_WIDTH
) (
    input  wire                      clock_i,
    input  wire                      s_reset,
    input  wire                      valid_i,
    input  wire [A_WIDTH-1:0]        a_i,
    input  wire [B_WIDTH-1:0]        b_i,
    input  wire                      unsigned_a_i,
    input  wire                      unsigned_b_i,
    input  dsp_pkg::feedback_t       feedback_i,
    input  wire                      subtract_i,
    input  dsp_pkg::shift_t          shift_right_i,
    input  wire                      round_i,
    input  wire                      saturate_i,
    output logic [Z_WIDTH-1:0]       z_o,
    output logic                     valid_o
);

    // Multiplier to accumulator
    logic                 prod_valid;
    logic [ACC_WIDTH-1:0] prod;
    logic                 prod_unsigned;
    dsp_pkg::feedback_t   prod_feedback;
    logic                 prod_subtract;
    dsp_pkg::shift_t      prod_shift;
    logic                 prod_round;
    logic                 prod_saturate;

    // Accumulator to output stage
    logic                 acc_valid;
    logic [ACC_WIDTH-1:0] acc_value;
    logic                 acc_unsigned;
    dsp_pkg::shift_t      acc_shift;
    logic                 acc_round;
    logic                 acc_saturate;

    dsp_multiplier #(
        .A_WIDTH   (A_WIDTH),
        .B_WIDTH   (B_WIDTH),
        .ACC_WIDTH (ACC_WIDTH)
    ) u_multiplier (
        .clock_i         (clock_i),
        .s_reset         (s_reset),
        .valid_i         (valid_i),
        .a_i             (a_i),
        .b_i             (b_i),
        .unsigned_a_i    (unsigned_a_i),
        .unsigned_b_i    (unsigned_b_i),
        .feedback_i      (feedback_i),
        .subtract_i      (subtract_i),
        .shift_right_i   (shift_right_i),
        .round_i         (round_i),
        .saturate_i      (saturate_i),
        .prod_valid_o    (prod_valid),
        .prod_o          (prod),
        .prod_unsigned_o (prod_unsigned),
        .feedback_o      (prod_feedback),
        .subtract_o      (prod_subtract),
        .shift_o         (prod_shift),
        .round_o         (prod_round),
        .saturate_o      (prod_saturate)
    );

    dsp_accumulator #(
        .ACC_WIDTH (ACC_WIDTH)
    ) u_accumulator (
        .clock_i         (clock_i),
        .s_reset         (s_reset),
        .prod_valid_i    (prod_valid),
        .prod_i          (prod),
        .prod_unsigned_i (prod_unsigned),
        .feedback_i      (prod_feedback),
        .subtract_i      (prod_subtract),
        .shift_i         (prod_shift),
        .round_i         (prod_round),
        .saturate_i      (prod_saturate),
        .acc_valid_o     (acc_valid),
        .acc_o           (acc_value),
        .acc_unsigned_o  (acc_unsigned),
        .shift_o         (acc_shift),
        .round_o         (acc_round),
        .saturate_o      (acc_saturate)
    );

    dsp_output_stage #(
        .ACC_WIDTH (ACC_WIDTH),
        .Z_WIDTH   (Z_WIDTH)
    ) u_output_stage (
        .clock_i        (clock_i),
        .s_reset        (s_reset),
        .acc_valid_i    (acc_valid),
        .acc_i          (acc_value),
        .acc_unsigned_i (acc_unsigned),
        .shift_i        (acc_shift),
        .round_i        (acc_round),
        .saturate_i     (acc_saturate),
        .z_o            (z_o),
        .valid_o        (valid_o)
    );

endmodule

`default_nettype wire

// ==== dsp_output_stage.sv ====
// DSP shift, round and saturate stage
`timescale 1ns/1ps
`default_nettype none

module dsp_output_stage #(
    parameter int ACC_WIDTH = 64,
    parameter int Z_WIDTH = 38
) (
    input  wire                      clock_i,
    input  wire                      s_reset,
    input  wire                      acc_valid_i,
    input  wire [ACC_WIDTH-1:0]      acc_i,
    input  wire                      acc_unsigned_i,
    input  dsp_pkg::shift_t          shift_i,
    input  wire                      round_i,
    input  wire                      saturate_i,
    output logic [Z_WIDTH-1:0]       z_o,
    output logic                     valid_o
);

    // Result cannot be wider than the accumulator
    if (Z_WIDTH > ACC_WIDTH) begin : g_z_width_check
        $error("Z_WIDTH must not exceed ACC_WIDTH");
    end

    // Saturation limits, held at accumulator width
    localparam logic [ACC_WIDTH-1:0] U_MAX = ACC_WIDTH'({Z_WIDTH{1'b1}});
    localparam logic [ACC_WIDTH-1:0] S_MAX = ACC_WIDTH'({(Z_WIDTH-1){1'b1}});
    localparam logic [ACC_WIDTH-1:0] S_MIN = ~S_MAX;

    logic signed [ACC_WIDTH-1:0] acc_shr;
    logic                        round_bit;
    logic [ACC_WIDTH-1:0]        acc_rnd;
    logic [ACC_WIDTH-1:0]        acc_sat;

    // Arithmetic shift keeps the sign
    assign acc_shr = $signed(acc_i) >>> shift_i;

    // Round half up, last bit shifted out
    assign round_bit = round_i && (shift_i != '0) && acc_i[shift_i - 1'b1];
    assign acc_rnd   = acc_shr + ACC_WIDTH'(round_bit);

    always_comb begin
        // Plain wrap by default
        acc_sat = acc_rnd;
        if (saturate_i) begin
            if (acc_unsigned_i) begin
                // Negative clamps to zero, overflow to all ones
                if (acc_rnd[ACC_WIDTH-1]) begin
                    acc_sat = '0;
                end else if (acc_rnd > U_MAX) begin
                    acc_sat = U_MAX;
                end
            end else begin
                // Signed clamp to the Z_WIDTH range
                if ($signed(acc_rnd) > $signed(S_MAX)) begin
                    acc_sat = S_MAX;
                end else if ($signed(acc_rnd) < $signed(S_MIN)) begin
                    acc_sat = S_MIN;
                end
            end
        end
    end

    // Registered result, held over idle cycles
    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            z_o     <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= acc_valid_i;
            if (acc_valid_i) begin
                z_o <= acc_sat[Z_WIDTH-1:0];
            end
        end
    end

    // One cycle from accumulator valid to output valid
    a_valid_follows: assert property (
        @(posedge clock_i) disable iff (s_reset) 1'b1 |=> (valid_o == $past(acc_valid_i))
    );

endmodule

`default_nettype wire

// ==== dsp_accumulator.sv ====
// DSP 64-bit accumulator stage
`timescale 1ns/1ps
`default_nettype none

module dsp_accumulator #(
    parameter int ACC_WIDTH = 64
) (
    input  wire                      clock_i,
    input  wire                      s_reset,
    input  wire                      prod_valid_i,
    input  wire [ACC_WIDTH-1:0]      prod_i,
    input  wire                      prod_unsigned_i,
    input  dsp_pkg::feedback_t       feedback_i,
    input  wire                      subtract_i,
    input  dsp_pkg::shift_t          shift_i,
    input  wire                      round_i,
    input  wire                      saturate_i,
    output logic                     acc_valid_o,
    output logic [ACC_WIDTH-1:0]     acc_o,
    output logic                     acc_unsigned_o,
    output dsp_pkg::shift_t          shift_o,
    output logic                     round_o,
    output logic                     saturate_o
);

    logic [ACC_WIDTH-1:0] acc_q;
    logic [ACC_WIDTH-1:0] addend;
    logic [ACC_WIDTH-1:0] base;
    logic [ACC_WIDTH-1:0] sum;

    // Two's complement negate for subtract
    assign addend = subtract_i ? (~prod_i + 1'b1) : prod_i;

    // Restart drops the running sum
    assign base = (feedback_i == dsp_pkg::FB_RESTART) ? '0 : acc_q;
    assign sum  = base + addend;

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            acc_q          <= '0;
            acc_valid_o    <= 1'b0;
            acc_unsigned_o <= 1'b0;
            shift_o        <= '0;
            round_o        <= 1'b0;
            saturate_o     <= 1'b0;
        end else begin
            acc_valid_o    <= prod_valid_i;
            // Hold the sum across gaps
            if (prod_valid_i) begin
                acc_q <= sum;
            end
            // Post-processing controls follow the data one stage on
            acc_unsigned_o <= prod_unsigned_i;
            shift_o        <= shift_i;
            round_o        <= round_i;
            saturate_o     <= saturate_i;
        end
    end

    // Stored sum feeds the output stage
    assign acc_o = acc_q;

    // Valid flag must stay clean out of reset
    a_acc_valid_known: assert property (
        @(posedge clock_i) disable iff (s_reset) !$isunknown(acc_valid_o)
    );

endmodule

`default_nettype wire

// ==== dsp_multiplier.sv ====
// DSP input registers and multiplier
`timescale 1ns/1ps
`default_nettype none

module dsp_multiplier #(
    parameter int A_WIDTH = 20,
    parameter int B_WIDTH = 18,
    parameter int ACC_WIDTH = 64
) (
    input  wire                      clock_i,
    input  wire                      s_reset,
    input  wire                      valid_i,
    input  wire [A_WIDTH-1:0]        a_i,
    input  wire [B_WIDTH-1:0]        b_i,
    input  wire                      unsigned_a_i,
    input  wire                      unsigned_b_i,
    input  dsp_pkg::feedback_t       feedback_i,
    input  wire                      subtract_i,
    input  dsp_pkg::shift_t          shift_right_i,
    input  wire                      round_i,
    input  wire                      saturate_i,
    output logic                     prod_valid_o,
    output logic [ACC_WIDTH-1:0]     prod_o,
    output logic                     prod_unsigned_o,
    output dsp_pkg::feedback_t       feedback_o,
    output logic                     subtract_o,
    output dsp_pkg::shift_t          shift_o,
    output logic                     round_o,
    output logic                     saturate_o
);

    localparam int P_WIDTH = A_WIDTH + B_WIDTH;

    // Product must fit the accumulator without loss
    if (ACC_WIDTH < P_WIDTH) begin : g_width_check
        $error("ACC_WIDTH must be at least A_WIDTH + B_WIDTH");
    end

    logic [A_WIDTH-1:0] a_q;
    logic [B_WIDTH-1:0] b_q;
    logic               unsigned_a_q;
    logic               unsigned_b_q;
    logic               neg_a;
    logic               neg_b;
    logic [A_WIDTH-1:0] mag_a;
    logic [B_WIDTH-1:0] mag_b;
    logic [P_WIDTH-1:0] mag_prod;
    logic [P_WIDTH-1:0] prod;

    // Operand payload registers
    always_ff @(posedge clock_i) begin
        a_q <= a_i;
        b_q <= b_i;
    end

    // Control path registered alongside the operands
    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            prod_valid_o <= 1'b0;
            unsigned_a_q <= 1'b0;
            unsigned_b_q <= 1'b0;
            feedback_o   <= dsp_pkg::FB_ACCUMULATE;
            subtract_o   <= 1'b0;
            shift_o      <= '0;
            round_o      <= 1'b0;
            saturate_o   <= 1'b0;
        end else begin
            prod_valid_o <= valid_i;
            unsigned_a_q <= unsigned_a_i;
            unsigned_b_q <= unsigned_b_i;
            feedback_o   <= feedback_i;
            subtract_o   <= subtract_i;
            shift_o      <= shift_right_i;
            round_o      <= round_i;
            saturate_o   <= saturate_i;
        end
    end

    // Negative only when top bit set and operand is signed
    assign neg_a = a_q[A_WIDTH-1] & ~unsigned_a_q;
    assign neg_b = b_q[B_WIDTH-1] & ~unsigned_b_q;

    // Sign-magnitude form, most negative value maps to 2^(N-1)
    assign mag_a = neg_a ? (~a_q + 1'b1) : a_q;
    assign mag_b = neg_b ? (~b_q + 1'b1) : b_q;

    assign mag_prod = P_WIDTH'(mag_a) * P_WIDTH'(mag_b);
    assign prod     = (neg_a ^ neg_b) ? (~mag_prod + 1'b1) : mag_prod;

    // Unsigned result only when both operands are unsigned
    assign prod_unsigned_o = unsigned_a_q & unsigned_b_q;

    // Zero or sign extension up to the accumulator width
    assign prod_o = prod_unsigned_o ? ACC_WIDTH'(prod) : ACC_WIDTH'($signed(prod));

endmodule

`default_nettype wire

// ==== dsp_pkg.sv ====
// DSP MAC shared definitions
`default_nettype none

package dsp_pkg;

    // Default operand widths of the 20x18 slice
    parameter int DSP_A_WIDTH = 20;
    parameter int DSP_B_WIDTH = 18;

    // Accumulator and result widths
    parameter int DSP_ACC_WIDTH = 64;
    parameter int DSP_Z_WIDTH = 38;

    // Right-shift amount, 0 to 63
    typedef logic [5:0] shift_t;

    // Feedback choice for the accumulator
    typedef logic [0:0] feedback_t;

    // Keep adding into the running sum
    parameter feedback_t FB_ACCUMULATE = 1'b0;
    // Drop the running sum, start from the product
    parameter feedback_t FB_RESTART = 1'b1;

endpackage

`default_nettype wire
